// ==== conv_dw_pkg.sv ====
`default_nettype none

package conv_dw_pkg;

  localparam int WORD_WIDTH = 16; // Accumulator word width.
  localparam int UNITS = 2; // Words per member.
  localparam int MEMBERS = 12; // Members per input beat.
  localparam int USER_WIDTH = 8;

  // Wide enough to hold a count from 0 up to MEMBERS.
  localparam int MEMBER_IDX_WIDTH = 4;

  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef word_t [UNITS-1:0] member_t;

  typedef member_t [MEMBERS-1:0] beat_t; // Member 0 sits in the low bits.

  typedef logic [USER_WIDTH-1:0] user_t;

  typedef logic [MEMBER_IDX_WIDTH-1:0] member_idx_t;

endpackage

`default_nettype wire

// ==== conv_dw_cfg_pkg.sv ====
`default_nettype none

package conv_dw_cfg_pkg;

  localparam int KW2_MAX = 2; // Kernel width is 2*kw2+1.
  localparam int SW_1_MAX = 1;

  localparam int KW2_WIDTH = 2;
  localparam int SW_1_WIDTH = 1;
  localparam int CFG_ADDR_WIDTH = 1;
  localparam int CFG_DATA_WIDTH = 8;

  typedef logic [KW2_WIDTH-1:0] kw2_t;
  typedef logic [SW_1_WIDTH-1:0] sw_1_t;
  typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;

  localparam cfg_addr_t ADDR_KW2 = 1'b0;
  localparam cfg_addr_t ADDR_SW_1 = 1'b1;

  // Kernel width 3 and stride 1 out of reset, so the group length is 3.
  localparam kw2_t KW2_RESET = 2'd1;
  localparam sw_1_t SW_1_RESET = 1'b0;

endpackage

`default_nettype wire

// ==== conv_out_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_out_cfg (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       cfg_wr,
  input  conv_dw_cfg_pkg::cfg_addr_t cfg_addr,
  input  conv_dw_cfg_pkg::cfg_data_t cfg_wdata,
  output conv_dw_pkg::member_idx_t   group_len,
  output conv_dw_pkg::member_idx_t   out_count
);

  conv_dw_cfg_pkg::kw2_t  kw2;
  conv_dw_cfg_pkg::sw_1_t sw_1;
  logic                   kw2_ok;
  logic                   sw_1_ok;

  assign kw2_ok = int'(cfg_wdata) <= conv_dw_cfg_pkg::KW2_MAX;
  assign sw_1_ok = int'(cfg_wdata) <= conv_dw_cfg_pkg::SW_1_MAX;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      kw2 <= conv_dw_cfg_pkg::KW2_RESET;
      sw_1 <= conv_dw_cfg_pkg::SW_1_RESET;
    end else if (cfg_wr) begin
      if (cfg_addr == conv_dw_cfg_pkg::ADDR_KW2 && kw2_ok) begin
        kw2 <= conv_dw_cfg_pkg::kw2_t'(cfg_wdata);
      end
      if (cfg_addr == conv_dw_cfg_pkg::ADDR_SW_1 && sw_1_ok) begin
        sw_1 <= conv_dw_cfg_pkg::sw_1_t'(cfg_wdata);
      end
    end
  end

  // Kernel width plus sw_1, the kernel width being {kw2, 1}.
  assign group_len = conv_dw_pkg::member_idx_t'({kw2, 1'b1})
                   + conv_dw_pkg::member_idx_t'(sw_1);

  // One member survives per complete group in the beat.
  assign out_count = conv_dw_pkg::member_idx_t'(conv_dw_pkg::MEMBERS / int'(group_len));

  // The sw_1 field cannot exceed its maximum at its width, so only kw2 is watched.
  a_cfg_in_range: assert property (@(posedge aclk) disable iff (!rst_n)
    int'(kw2) <= conv_dw_cfg_pkg::KW2_MAX)
    else $error("Configuration register holds an illegal value.");

endmodule

`default_nettype wire

// ==== dw_member_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module dw_member_select (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     s_valid,
  output logic                     s_ready,
  input  conv_dw_pkg::beat_t       s_data,
  input  conv_dw_pkg::user_t       s_user,
  input  logic                     s_last,
  input  conv_dw_pkg::member_idx_t group_len,
  input  conv_dw_pkg::member_idx_t out_count,
  output logic                     a_valid,
  input  logic                     a_ready,
  output conv_dw_pkg::beat_t       a_data,
  output conv_dw_pkg::member_idx_t a_count,
  output conv_dw_pkg::user_t       a_user,
  output logic                     a_last
);

  conv_dw_pkg::beat_t packed_data;
  logic               running;
  logic               s_fire;

  // Walk the members once, keeping the last member of every group.
  always_comb begin
    conv_dw_pkg::member_idx_t phase;
    conv_dw_pkg::member_idx_t slot;
    packed_data = '0;
    phase = '0;
    slot = '0;
    for (int m = 0; m < conv_dw_pkg::MEMBERS; m++) begin
      if (phase == group_len - 1'b1) begin
        packed_data[slot] = s_data[m];
        slot = slot + 1'b1;
        phase = '0;
      end else begin
        phase = phase + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      running <= 1'b0; // Keeps s_ready low until reset is released.
    end else begin
      running <= 1'b1;
    end
  end

  assign s_ready = running && (!a_valid || a_ready);
  assign s_fire = s_valid && s_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      a_valid <= 1'b0;
    end else if (s_fire) begin
      a_valid <= 1'b1;
    end else if (a_ready) begin
      a_valid <= 1'b0;
    end
  end

  // The configuration is frozen with the beat here.
  always_ff @(posedge aclk) begin
    if (s_fire) begin
      a_data <= packed_data;
      a_count <= out_count;
      a_user <= s_user;
      a_last <= s_last;
    end
  end

  a_valid_has_members: assert property (@(posedge aclk) disable iff (!rst_n)
    a_valid |-> a_count != '0)
    else $error("Packed beat carries no members.");

endmodule

`default_nettype wire

// ==== dw_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dw_serializer (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     a_valid,
  output logic                     a_ready,
  input  conv_dw_pkg::beat_t       a_data,
  input  conv_dw_pkg::member_idx_t a_count,
  input  conv_dw_pkg::user_t       a_user,
  input  logic                     a_last,
  output logic                     b_valid,
  input  logic                     b_ready,
  output conv_dw_pkg::member_t     b_data,
  output conv_dw_pkg::user_t       b_user,
  output logic                     b_last
);

  typedef enum logic {
    SER_IDLE,
    SER_SHIFT
  } ser_state_t;

  ser_state_t               state;
  conv_dw_pkg::beat_t       hold;
  conv_dw_pkg::member_idx_t remaining; // Members left, the current one included.
  conv_dw_pkg::user_t       user_q;
  logic                     last_q;
  logic                     final_member;
  logic                     load;
  logic                     b_fire;

  assign final_member = remaining == conv_dw_pkg::member_idx_t'(1);
  assign a_ready = state == SER_IDLE || (final_member && b_ready);
  assign load = a_valid && a_ready;
  assign b_fire = b_valid && b_ready;

  assign b_valid = state == SER_SHIFT;
  assign b_data = hold[0];
  assign b_user = user_q;
  assign b_last = last_q && final_member;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state <= SER_IDLE;
      remaining <= '0;
    end else if (load) begin
      state <= SER_SHIFT; // Also covers a back to back load on the final member.
      remaining <= a_count;
    end else if (b_fire) begin
      remaining <= remaining - 1'b1;
      if (final_member) begin
        state <= SER_IDLE;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      hold <= a_data;
      user_q <= a_user;
      last_q <= a_last;
    end else if (b_fire) begin
      hold <= {conv_dw_pkg::member_t'('0), hold[conv_dw_pkg::MEMBERS-1:1]};
    end
  end

  a_load_when_drained: assert property (@(posedge aclk) disable iff (!rst_n)
    load |-> remaining == '0 || (final_member && b_fire))
    else $error("Serializer loaded a beat with members still unsent.");

endmodule

`default_nettype wire

// ==== axis_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_skid (
  input  logic                 aclk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  conv_dw_pkg::member_t s_data,
  input  conv_dw_pkg::user_t   s_user,
  input  logic                 s_last,
  output logic                 m_valid,
  input  logic                 m_ready,
  output conv_dw_pkg::member_t m_data,
  output conv_dw_pkg::user_t   m_user,
  output logic                 m_last
);

  conv_dw_pkg::member_t skid_data;
  conv_dw_pkg::user_t   skid_user;
  logic                 skid_last;
  logic                 skid_valid;
  logic                 skid_valid_next;
  logic                 out_free;
  logic                 s_fire;

  assign out_free = !m_valid || m_ready;
  assign s_fire = s_valid && s_ready;
  assign skid_valid_next = out_free ? 1'b0 : (skid_valid || s_fire);

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      skid_valid <= 1'b0;
      s_ready <= 1'b0;
    end else begin
      if (out_free) begin
        m_valid <= skid_valid || s_fire;
      end
      skid_valid <= skid_valid_next;
      s_ready <= !skid_valid_next; // Ready is a flop so the input side sees no m_ready path.
    end
  end

  always_ff @(posedge aclk) begin
    if (out_free) begin
      m_data <= skid_valid ? skid_data : s_data;
      m_user <= skid_valid ? skid_user : s_user;
      m_last <= skid_valid ? skid_last : s_last;
    end
    if (s_ready && !out_free) begin
      skid_data <= s_data;
      skid_user <= s_user;
      skid_last <= s_last;
    end
  end

  a_hold_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("Output data changed while stalled.");

endmodule

`default_nettype wire

// ==== conv_dw_shift_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_dw_shift_top (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       cfg_wr,
  input  conv_dw_cfg_pkg::cfg_addr_t cfg_addr,
  input  conv_dw_cfg_pkg::cfg_data_t cfg_wdata,
  input  logic                       s_valid,
  output logic                       s_ready,
  input  conv_dw_pkg::beat_t         s_data,
  input  conv_dw_pkg::user_t         s_user,
  input  logic                       s_last,
  output logic                       m_valid,
  input  logic                       m_ready,
  output conv_dw_pkg::member_t       m_data,
  output conv_dw_pkg::user_t         m_user,
  output logic                       m_last
);

  conv_dw_pkg::member_idx_t group_len;
  conv_dw_pkg::member_idx_t out_count;

  logic                     a_valid;
  logic                     a_ready;
  conv_dw_pkg::beat_t       a_data;
  conv_dw_pkg::member_idx_t a_count;
  conv_dw_pkg::user_t       a_user;
  logic                     a_last;

  logic                     b_valid;
  logic                     b_ready;
  conv_dw_pkg::member_t     b_data;
  conv_dw_pkg::user_t       b_user;
  logic                     b_last;

  conv_out_cfg cfg_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .group_len (group_len),
    .out_count (out_count)
  );

  dw_member_select select_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .s_user    (s_user),
    .s_last    (s_last),
    .group_len (group_len),
    .out_count (out_count),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .a_count   (a_count),
    .a_user    (a_user),
    .a_last    (a_last)
  );

  dw_serializer serializer_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .a_data  (a_data),
    .a_count (a_count),
    .a_user  (a_user),
    .a_last  (a_last),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .b_data  (b_data),
    .b_user  (b_user),
    .b_last  (b_last)
  );

  axis_skid slice_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (b_valid),
    .s_ready (b_ready),
    .s_data  (b_data),
    .s_user  (b_user),
    .s_last  (b_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_user  (m_user),
    .m_last  (m_last)
  );

endmodule

`default_nettype wire

// ==== tb_conv_dw_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_dw_checker (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       cfg_wr,
  input  conv_dw_cfg_pkg::cfg_addr_t cfg_addr,
  input  conv_dw_cfg_pkg::cfg_data_t cfg_wdata,
  input  logic                       s_valid,
  input  logic                       s_ready,
  input  conv_dw_pkg::beat_t         s_data,
  input  conv_dw_pkg::user_t         s_user,
  input  logic                       s_last,
  input  logic                       m_valid,
  input  logic                       m_ready,
  input  conv_dw_pkg::member_t       m_data,
  input  conv_dw_pkg::user_t         m_user,
  input  logic                       m_last,
  input  logic                       end_test,
  output int                         errors,
  output int                         pending
);

  conv_dw_pkg::member_t exp_data[$];
  conv_dw_pkg::user_t   exp_user[$];
  logic                 exp_last[$];
  int                   kw2 = conv_dw_cfg_pkg::KW2_RESET;
  int                   sw_1 = conv_dw_cfg_pkg::SW_1_RESET;
  int                   err_count = 0;
  int                   depth = 0;

  assign errors = err_count;
  assign pending = depth;

  // Sampled at the falling edge, where every signal holds the value of the next rising edge.
  always @(negedge aclk) begin
    int                   gl;
    conv_dw_pkg::member_t want_data;
    conv_dw_pkg::user_t   want_user;
    logic                 want_last;
    gl = 2 * kw2 + 1 + sw_1;
    if (rst_n && s_valid && s_ready) begin
      for (int m = 0; m < conv_dw_pkg::MEMBERS; m++) begin
        if (m % gl == gl - 1) begin
          exp_data.push_back(s_data[m]);
          exp_user.push_back(s_user);
          exp_last.push_back(s_last && (m + gl >= conv_dw_pkg::MEMBERS)); // No later group fits.
        end
      end
    end
    if (!rst_n) begin
      kw2 = conv_dw_cfg_pkg::KW2_RESET;
      sw_1 = conv_dw_cfg_pkg::SW_1_RESET;
    end else if (cfg_wr) begin
      if (cfg_addr == conv_dw_cfg_pkg::ADDR_KW2
          && int'(cfg_wdata) <= conv_dw_cfg_pkg::KW2_MAX) begin
        kw2 = int'(cfg_wdata);
      end
      if (cfg_addr == conv_dw_cfg_pkg::ADDR_SW_1
          && int'(cfg_wdata) <= conv_dw_cfg_pkg::SW_1_MAX) begin
        sw_1 = int'(cfg_wdata);
      end
    end
    if (rst_n && m_valid && m_ready) begin
      if (exp_data.size() == 0) begin
        $display("Unexpected output at %0t: no member was waiting for it.", $time);
        err_count++;
      end else begin
        want_data = exp_data.pop_front();
        want_user = exp_user.pop_front();
        want_last = exp_last.pop_front();
        if (m_data !== want_data) begin
          $display("error at %0t: m_data expected %h, actual %h", $time, want_data, m_data);
          err_count++;
        end
        if (m_user !== want_user) begin
          $display("error at %0t: m_user expected %h, actual %h", $time, want_user, m_user);
          err_count++;
        end
        if (m_last !== want_last) begin
          $display("error at %0t: m_last expected %b, actual %b", $time, want_last, m_last);
          err_count++;
        end
      end
    end
    if (end_test && exp_data.size() != 0) begin
      $display("%0d expected outputs are missing at the end of the test.", exp_data.size());
      err_count++;
      exp_data.delete();
      exp_user.delete();
      exp_last.delete();
    end
    depth = exp_data.size();
  end

endmodule

`default_nettype wire

// ==== tb_conv_dw_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_dw_shift;

  localparam int TOTAL_BEATS = 8 + 6 * 20 + 40 + 16 + 16;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * conv_dw_pkg::MEMBERS * 4 + 200;
  localparam logic [15:0] LFSR_SEED = 16'd29155;

  logic                       aclk;
  logic                       rst_n;
  logic                       cfg_wr;
  conv_dw_cfg_pkg::cfg_addr_t cfg_addr;
  conv_dw_cfg_pkg::cfg_data_t cfg_wdata;
  logic                       s_valid;
  logic                       s_ready;
  conv_dw_pkg::beat_t         s_data;
  conv_dw_pkg::user_t         s_user;
  logic                       s_last;
  logic                       m_valid;
  logic                       m_ready;
  conv_dw_pkg::member_t       m_data;
  conv_dw_pkg::user_t         m_user;
  logic                       m_last;
  logic                       end_test;
  logic                       stall_en;
  int                         chk_errors;
  int                         chk_pending;
  logic [15:0]                lfsr = LFSR_SEED;
  int                         tb_errors = 0;
  int                         tests_passed = 0;
  int                         tests_failed = 0;
  int                         errs_at_start = 0;
  int                         cycle_count = 0;

  conv_dw_shift_top dut_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .s_user    (s_user),
    .s_last    (s_last),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_user    (m_user),
    .m_last    (m_last)
  );

  tb_conv_dw_checker checker_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .s_user    (s_user),
    .s_last    (s_last),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_user    (m_user),
    .m_last    (m_last),
    .end_test  (end_test),
    .errors    (chk_errors),
    .pending   (chk_pending)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  // m_ready has its own generator, so the stall pattern does not shift the data stream.
  initial begin
    logic [15:0] stall_lfsr;
    logic        stalls_on;
    logic        low_a;
    stall_lfsr = LFSR_SEED;
    m_ready = 1'b1;
    forever begin
      @(posedge aclk);
      stalls_on = stall_en;
      #1;
      if (stalls_on) begin
        stall_lfsr = lfsr_step(stall_lfsr);
        low_a = stall_lfsr[0];
        stall_lfsr = lfsr_step(stall_lfsr);
        m_ready = !(low_a && stall_lfsr[0]); // Low about one cycle in four.
      end else begin
        m_ready = 1'b1;
      end
    end
  end

  task automatic expect_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b, actual %b", $time, name, exp, act);
      tb_errors++;
    end
  endtask

  task automatic write_cfg(input conv_dw_cfg_pkg::cfg_addr_t addr,
                           input conv_dw_cfg_pkg::cfg_data_t data);
    cfg_wr = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge aclk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic run_beats(input int n, input bit gaps, input bit stalls, input bit all_last);
    logic accepted;
    stall_en = stalls;
    for (int b = 0; b < n; b++) begin
      if (gaps) begin
        s_valid = 1'b0;
        repeat (take_bits(2)) begin
          @(posedge aclk);
          #1;
        end
      end
      for (int w = 0; w < conv_dw_pkg::MEMBERS; w++) begin
        for (int u = 0; u < conv_dw_pkg::UNITS; u++) begin
          s_data[w][u] = conv_dw_pkg::word_t'(take_bits(conv_dw_pkg::WORD_WIDTH));
        end
      end
      s_user = conv_dw_pkg::user_t'(take_bits(conv_dw_pkg::USER_WIDTH));
      s_last = take_bits(1) != 0 || all_last;
      s_valid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge aclk);
        accepted = s_ready;
        @(posedge aclk);
        #1;
      end
      s_valid = 1'b0;
    end
    stall_en = 1'b0;
  endtask

  task automatic close_test(input string name);
    int errs_now;
    while (chk_pending != 0) begin
      @(posedge aclk);
      #1;
    end
    repeat (8) begin // Room for a late duplicate to show up.
      @(posedge aclk);
      #1;
    end
    end_test = 1'b1;
    @(posedge aclk);
    #1;
    end_test = 1'b0;
    errs_now = tb_errors + chk_errors;
    if (errs_now == errs_at_start) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errs_now - errs_at_start);
      tests_failed++;
    end
    errs_at_start = errs_now;
  endtask

  initial begin
    rst_n = 1'b0;
    cfg_wr = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    s_valid = 1'b0;
    s_data = '0;
    s_user = '0;
    s_last = 1'b0;
    end_test = 1'b0;
    stall_en = 1'b0;
    repeat (8) begin
      @(posedge aclk);
      #1;
      expect_bit("m_valid", 1'b0, m_valid);
      expect_bit("s_ready", 1'b0, s_ready);
    end
    rst_n = 1'b1;
    @(posedge aclk);
    #1;
    expect_bit("s_ready", 1'b1, s_ready);
    run_beats(8, 1'b0, 1'b0, 1'b0); // Group length 3 out of reset.
    close_test("reset configuration");

    for (int k = 0; k <= conv_dw_cfg_pkg::KW2_MAX; k++) begin
      for (int s = 0; s <= conv_dw_cfg_pkg::SW_1_MAX; s++) begin
        write_cfg(conv_dw_cfg_pkg::ADDR_KW2, conv_dw_cfg_pkg::cfg_data_t'(k));
        write_cfg(conv_dw_cfg_pkg::ADDR_SW_1, conv_dw_cfg_pkg::cfg_data_t'(s));
        run_beats(20, 1'b0, 1'b0, 1'b0);
        close_test($sformatf("kw2=%0d sw_1=%0d", k, s));
      end
    end

    write_cfg(conv_dw_cfg_pkg::ADDR_KW2, 8'd1);
    write_cfg(conv_dw_cfg_pkg::ADDR_SW_1, 8'd1);
    run_beats(40, 1'b1, 1'b1, 1'b0);
    close_test("gaps and stalls");

    write_cfg(conv_dw_cfg_pkg::ADDR_KW2, 8'd0);
    write_cfg(conv_dw_cfg_pkg::ADDR_SW_1, 8'd0);
    run_beats(16, 1'b1, 1'b1, 1'b1);
    close_test("last on every beat");

    write_cfg(conv_dw_cfg_pkg::ADDR_KW2, 8'd2);
    write_cfg(conv_dw_cfg_pkg::ADDR_SW_1, 8'd1);
    write_cfg(conv_dw_cfg_pkg::ADDR_KW2, 8'd3);
    write_cfg(conv_dw_cfg_pkg::ADDR_SW_1, 8'd2);
    write_cfg(conv_dw_cfg_pkg::ADDR_KW2, 8'hff);
    run_beats(16, 1'b1, 1'b1, 1'b0);
    close_test("illegal writes ignored");

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, tb_errors + chk_errors);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_dw_shift.f ====
conv_dw_pkg.sv
conv_dw_cfg_pkg.sv
conv_out_cfg.sv
dw_member_select.sv
dw_serializer.sv
axis_skid.sv
conv_dw_shift_top.sv
tb_conv_dw_checker.sv
tb_conv_dw_shift.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= conv_dw_shift.f
TB_TOP     ?= tb_conv_dw_shift
RTL_TOP    ?= conv_dw_shift_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
FAIL_MSG   := ** FAIL **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) $(LINT_FLAGS) \
	  --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "Simulation failed, see $(LOG)."; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
